// ==== ddr_traffic_gen.f ====
+incdir+verilog
verilog/tg_pkg.sv
verilog/tg_addr_if.sv
verilog/lfsr8.sv
verilog/pattern_gen.sv
verilog/addr_sweep.sv
verilog/traffic_ctrl.sv
verilog/read_checker.sv
verilog/ddr_traffic_gen.sv
verif/tb_mem_model.sv
verif/tb_ddr_traffic_gen.sv

// ==== verif/tb_ddr_traffic_gen.sv ====
`timescale 1ns/1ps
`include "tg_params.svh"

module tb_ddr_traffic_gen;
  import tg_pkg::*;

  localparam int BURSTS = (`TG_MAX_CS + 1) * (`TG_MAX_BANK + 1) * (`TG_MAX_ROW + 1) *
                          (`TG_MAX_COL / `TG_COL_STEP + 1);
  localparam int PASS_BEATS   = BURSTS * `TG_BURST_LEN;
  localparam int STALL_MARGIN = 8;
  localparam int WATCHDOG_CYC = 2 * BURSTS * (2 * `TG_BURST_LEN + 1) * STALL_MARGIN;
  localparam int FLIP_BEAT    = 101;
  localparam int FLIP_LANE    = 5;
  localparam lane_mask_t FLIP_MASK = ~lane_mask_t'(1 << FLIP_LANE);

  logic       clk;
  logic       reset_n;
  logic       local_ready;
  logic       local_rdata_valid;
  data_t      local_rdata;
  cs_t        local_cs_addr;
  bank_t      local_bank_addr;
  row_t       local_row_addr;
  col_t       local_col_addr;
  logic       local_write_req;
  logic       local_read_req;
  logic       local_burstbegin;
  logic [3:0] local_size;
  data_t      local_wdata;
  lane_mask_t pnf_per_byte;
  logic       pnf_persist;
  logic       test_complete;
  logic       flip_en;
  int         flip_beat;
  logic       flipped;

  // reference state of the monitor
  lane_t ref_lane [`TG_LANES];
  cs_t   w_cs;
  bank_t w_bank;
  row_t  w_row;
  col_t  w_col;
  cs_t   r_cs;
  bank_t r_bank;
  row_t  r_row;
  col_t  r_col;
  int    w_beat;
  int    wr_beats;
  int    rd_bursts;
  int    tc_cnt;
  int    pass_count = 0;
  bit    pass_bad;
  bit    persist_low;
  bit    err_seen = 1'b0;
  logic  vld_d1;
  logic  flip_d1;
  logic  vld_d2;
  logic  flip_d2;
  logic  prev_req;
  logic  prev_rdy;
  logic  prev_wr;
  logic  prev_rd;
  logic  prev_bb;
  logic [26:0] prev_addr;
  data_t prev_wdata;

  ddr_traffic_gen dut (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .local_rdata       (local_rdata),
    .local_cs_addr     (local_cs_addr),
    .local_bank_addr   (local_bank_addr),
    .local_row_addr    (local_row_addr),
    .local_col_addr    (local_col_addr),
    .local_write_req   (local_write_req),
    .local_read_req    (local_read_req),
    .local_burstbegin  (local_burstbegin),
    .local_size        (local_size),
    .local_wdata       (local_wdata),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .test_complete     (test_complete)
  );

  tb_mem_model u_mem (
    .clk         (clk),
    .reset_n     (reset_n),
    .write_req   (local_write_req),
    .read_req    (local_read_req),
    .burstbegin  (local_burstbegin),
    .cs_addr     (local_cs_addr),
    .bank_addr   (local_bank_addr),
    .row_addr    (local_row_addr),
    .col_addr    (local_col_addr),
    .wdata       (local_wdata),
    .flip_en     (flip_en),
    .flip_beat   (flip_beat),
    .flip_lane   (FLIP_LANE),
    .ready       (local_ready),
    .rdata_valid (local_rdata_valid),
    .rdata       (local_rdata),
    .flipped     (flipped)
  );

  initial
    clk = 1'b0;

  always #10 clk = ~clk;

  // ----------------------------------------
  // reference models
  // ----------------------------------------
  function automatic lane_t lfsr_next(lane_t d);
    return {d[6:0], d[7] ^ d[5] ^ d[4] ^ d[3]};
  endfunction

  function automatic void sweep_next(inout cs_t cs, inout bank_t bank,
                                     inout row_t row, inout col_t col);
    if (col != `TG_MAX_COL)
      col = col + `TG_COL_STEP;
    else
    begin
      col = '0;
      if (row != `TG_MAX_ROW)
        row = row + 1'b1;
      else
      begin
        row = '0;
        if (bank != `TG_MAX_BANK)
          bank = bank + 1'b1;
        else
        begin
          bank = '0;
          cs   = (cs == `TG_MAX_CS) ? '0 : cs + 1'b1;
        end
      end
    end
  endfunction

  function automatic data_t ref_word();
    data_t w;
    for (int k = 0; k < `TG_LANES; k++)
      w[k] = ref_lane[k];
    return w;
  endfunction

  task automatic expect_eq(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
    if (actual !== expected)
    begin
      $display("ERROR at %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at the first mismatch");
    end
  endtask

  task automatic restart_refs();
    for (int k = 0; k < `TG_LANES; k++)
      ref_lane[k] = lane_t'(`TG_SEED_BASE + k * `TG_SEED_STEP);
    {w_cs, w_bank, w_row, w_col} = '0;
    {r_cs, r_bank, r_row, r_col} = '0;
    w_beat      = 0;
    wr_beats    = 0;
    rd_bursts   = 0;
    tc_cnt      = 0;
    pass_bad    = 1'b0;
    persist_low = 1'b0;
    {vld_d1, flip_d1, vld_d2, flip_d2} = '0;
    prev_req    = 1'b0;
  endtask

  // ----------------------------------------
  // monitor and compare
  // ----------------------------------------
  always @(posedge clk)
  begin
    if (!reset_n)
      restart_refs();
    else
    begin
      if (persist_low)
        expect_eq(pnf_persist, 1'b0, "pnf_persist after lane error");
      // lane result lands two cycles after the returned beat
      if (vld_d2)
      begin
        expect_eq(pnf_per_byte, flip_d2 ? FLIP_MASK : 8'hff, "pnf_per_byte");
        if (flip_d2)
        begin
          persist_low = 1'b1;
          err_seen    = 1'b1;
          pass_bad    = 1'b1;
        end
      end
      {vld_d2, flip_d2} = {vld_d1, flip_d1};
      {vld_d1, flip_d1} = {local_rdata_valid, flipped};

      if (prev_req && !prev_rdy)
      begin
        expect_eq(local_write_req, prev_wr, "write request dropped in stall");
        expect_eq(local_read_req, prev_rd, "read request dropped in stall");
        expect_eq(local_burstbegin, prev_bb, "burstbegin changed in stall");
        expect_eq({local_cs_addr, local_bank_addr, local_row_addr, local_col_addr},
                  prev_addr, "address changed in stall");
        if (prev_wr)
          expect_eq(local_wdata, prev_wdata, "write data changed in stall");
      end
      expect_eq(local_write_req && local_read_req, 1'b0, "read and write request together");
      if (local_read_req)
        expect_eq(wr_beats, PASS_BEATS, "read request before last write beat");

      if (local_write_req && local_ready)
      begin
        expect_eq({local_cs_addr, local_bank_addr, local_row_addr, local_col_addr},
                  {w_cs, w_bank, w_row, w_col}, "write address");
        expect_eq(local_burstbegin, w_beat == 0, "write burstbegin");
        expect_eq(local_wdata, ref_word(), "write data");
        for (int k = 0; k < `TG_LANES; k++)
          ref_lane[k] = lfsr_next(ref_lane[k]);
        w_beat++;
        wr_beats++;
        if (w_beat == `TG_BURST_LEN)
        begin
          w_beat = 0;
          sweep_next(w_cs, w_bank, w_row, w_col);
        end
      end

      if (local_read_req && local_ready)
      begin
        expect_eq({local_cs_addr, local_bank_addr, local_row_addr, local_col_addr},
                  {r_cs, r_bank, r_row, r_col}, "read address");
        expect_eq(local_burstbegin, 1'b1, "read burstbegin");
        rd_bursts++;
        sweep_next(r_cs, r_bank, r_row, r_col);
      end

      // pnf_persist has settled by the second cycle of test_complete
      if (test_complete)
      begin
        tc_cnt++;
        if (tc_cnt == 2)
        begin
          expect_eq(wr_beats, PASS_BEATS, "write beats in pass");
          expect_eq(rd_bursts, BURSTS, "read bursts in pass");
          expect_eq(pnf_persist, !pass_bad, "pnf_persist at end of pass");
          expect_eq(pnf_per_byte, 8'hff, "pnf_per_byte at end of pass");
          expect_eq(local_size, `TG_BURST_LEN, "local_size");
          wr_beats  = 0;
          rd_bursts = 0;
          pass_bad  = 1'b0;
          pass_count++;
        end
      end
      else if (tc_cnt != 0)
      begin
        expect_eq(tc_cnt, 2, "test_complete pulse length");
        tc_cnt = 0;
      end

      prev_req   = local_write_req || local_read_req;
      prev_rdy   = local_ready;
      prev_wr    = local_write_req;
      prev_rd    = local_read_req;
      prev_bb    = local_burstbegin;
      prev_addr  = {local_cs_addr, local_bank_addr, local_row_addr, local_col_addr};
      prev_wdata = local_wdata;
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial
  begin
    reset_n   = 1'b0;
    flip_en   = 1'b0;
    flip_beat = FLIP_BEAT;
    repeat (4) @(posedge clk);
    #1 reset_n = 1'b1;
    // two clean passes
    wait (pass_count == 2);
    @(posedge clk);
    #1 reset_n = 1'b0;
    flip_en = 1'b1;
    repeat (4) @(posedge clk);
    #1 reset_n = 1'b1;
    // rerun with one corrupted read beat
    wait (pass_count == 3);
    if (!err_seen)
    begin
      $display("the injected lane error never reached pnf_per_byte");
      $display("SOME TESTS FAILED");
      $fatal(1, "injected error not observed");
    end
    else
    begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

  // sized for two passes of stalled traffic plus the rerun
  initial
  begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("watchdog expired: the run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

endmodule

// ==== verif/tb_mem_model.sv ====
`timescale 1ns/1ps
`include "tg_params.svh"

module tb_mem_model (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          write_req,
  input  logic          read_req,
  input  logic          burstbegin,
  input  tg_pkg::cs_t   cs_addr,
  input  tg_pkg::bank_t bank_addr,
  input  tg_pkg::row_t  row_addr,
  input  tg_pkg::col_t  col_addr,
  input  tg_pkg::data_t wdata,
  input  logic          flip_en,
  input  int            flip_beat,
  input  int            flip_lane,
  output logic          ready,
  output logic          rdata_valid,
  output tg_pkg::data_t rdata,
  output logic          flipped
);
  import tg_pkg::*;

  // address in the upper bits, beat number in the low nibble
  typedef logic [`TG_CS_W+`TG_BANK_W+`TG_ROW_W+`TG_COL_W+3:0] key_t;

  data_t  mem [key_t];
  data_t  rd_q [$];
  key_t   base;
  int     wr_beat;
  int     rd_beats;
  int     gap;
  int     b;
  integer seed = 32'h364d45e2;
  integer r;

  initial
  begin
    ready       = 1'b0;
    rdata_valid = 1'b0;
    rdata       = '0;
    flipped     = 1'b0;
    wr_beat     = 0;
    rd_beats    = 0;
    gap         = 0;
  end

  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      rd_q.delete();
      wr_beat  = 0;
      rd_beats = 0;
      gap      = 0;
      #1;
      ready       = 1'b0;
      rdata_valid = 1'b0;
      flipped     = 1'b0;
    end
    else
    begin
      base = {cs_addr, bank_addr, row_addr, col_addr, 4'd0};
      if (write_req && ready)
      begin
        if (burstbegin)
          wr_beat = 0;
        mem[base + key_t'(wr_beat)] = wdata;
        wr_beat++;
      end
      // a read request queues a whole burst
      if (read_req && ready)
      begin
        for (b = 0; b < `TG_BURST_LEN; b++)
          rd_q.push_back(mem.exists(base + key_t'(b)) ? mem[base + key_t'(b)] : '0);
      end
      r = $random(seed);
      #1;
      ready       = (r[1:0] != 2'b00);
      rdata_valid = 1'b0;
      flipped     = 1'b0;
      if (gap > 0)
        gap--;
      else if (rd_q.size() > 0)
      begin
        rdata   = rd_q.pop_front();
        flipped = flip_en && (rd_beats == flip_beat);
        if (flipped)
          rdata[flip_lane] = ~rdata[flip_lane];
        rdata_valid = 1'b1;
        rd_beats++;
        // random spacing before the next returned beat
        r   = $random(seed);
        gap = r[1:0];
      end
    end
  end

endmodule

// ==== verilog/addr_sweep.sv ====
`timescale 1ns/1ps
`include "tg_params.svh"

module addr_sweep (
  input logic      clk,
  input logic      reset_n,
  tg_addr_if.sweep addr
);
  import tg_pkg::*;

  localparam col_t  MAX_COL  = col_t'(`TG_MAX_COL);
  localparam row_t  MAX_ROW  = row_t'(`TG_MAX_ROW);
  localparam bank_t MAX_BANK = bank_t'(`TG_MAX_BANK);
  localparam cs_t   MAX_CS   = cs_t'(`TG_MAX_CS);
  localparam col_t  COL_STEP = col_t'(`TG_COL_STEP);

  // ----------------------------------------
  // column, then row, bank and chip select
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      addr.cs   <= '0;
      addr.bank <= '0;
      addr.row  <= '0;
      addr.col  <= '0;
    end
    else if (addr.clear)
    begin
      addr.cs   <= '0;
      addr.bank <= '0;
      addr.row  <= '0;
      addr.col  <= '0;
    end
    else if (addr.step)
    begin
      if (addr.col == MAX_COL)
      begin
        addr.col <= '0;
        if (addr.row == MAX_ROW)
        begin
          addr.row <= '0;
          if (addr.bank == MAX_BANK)
          begin
            addr.bank <= '0;
            if (addr.cs == MAX_CS)
              addr.cs <= '0;
            else
              addr.cs <= addr.cs + 1'b1;
          end
          else
            addr.bank <= addr.bank + 1'b1;
        end
        else
          addr.row <= addr.row + 1'b1;
      end
      else
        addr.col <= addr.col + COL_STEP;
    end
  end

  // final address of the sweep
  assign addr.last = (addr.col == MAX_COL) && (addr.row == MAX_ROW) &&
                     (addr.bank == MAX_BANK) && (addr.cs == MAX_CS);

  // column steps must land on the limit before wrapping
  col_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    addr.col <= MAX_COL);

endmodule

// ==== verilog/ddr_traffic_gen.sv ====
`timescale 1ns/1ps
`include "tg_params.svh"

module ddr_traffic_gen (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               local_ready,
  input  logic               local_rdata_valid,
  input  tg_pkg::data_t      local_rdata,
  output tg_pkg::cs_t        local_cs_addr,
  output tg_pkg::bank_t      local_bank_addr,
  output tg_pkg::row_t       local_row_addr,
  output tg_pkg::col_t       local_col_addr,
  output logic               local_write_req,
  output logic               local_read_req,
  output logic               local_burstbegin,
  output logic [3:0]         local_size,
  output tg_pkg::data_t      local_wdata,
  output tg_pkg::lane_mask_t pnf_per_byte,
  output logic               pnf_persist,
  output logic               test_complete
);

  logic gen_step;
  logic gen_capture;
  logic gen_reload;

  tg_addr_if addr_bus ();

  assign local_cs_addr   = addr_bus.cs;
  assign local_bank_addr = addr_bus.bank;
  assign local_row_addr  = addr_bus.row;
  assign local_col_addr  = addr_bus.col;
  assign local_size      = 4'(`TG_BURST_LEN);

  addr_sweep u_sweep (
    .clk     (clk),
    .reset_n (reset_n),
    .addr    (addr_bus.sweep)
  );

  traffic_ctrl u_ctrl (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .addr              (addr_bus.ctrl),
    .write_req         (local_write_req),
    .read_req          (local_read_req),
    .burst_begin       (local_burstbegin),
    .gen_step          (gen_step),
    .gen_capture       (gen_capture),
    .gen_reload        (gen_reload),
    .test_complete     (test_complete)
  );

  // write data and expected read data come from the same lanes
  pattern_gen u_pattern (
    .clk     (clk),
    .reset_n (reset_n),
    .step    (gen_step),
    .capture (gen_capture),
    .reload  (gen_reload),
    .pattern (local_wdata)
  );

  read_checker u_checker (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_rdata_valid (local_rdata_valid),
    .local_rdata       (local_rdata),
    .expected          (local_wdata),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist)
  );

endmodule

// ==== verilog/lfsr8.sv ====
`timescale 1ns/1ps

module lfsr8 #(
  parameter tg_pkg::lane_t seed = 8'd1
) (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          enable,
  input  logic          pause,
  input  logic          load,
  input  tg_pkg::lane_t ldata,
  output tg_pkg::lane_t data
);

  logic feedback;

  // taps on bits 7, 5, 4 and 3
  assign feedback = data[7] ^ data[5] ^ data[4] ^ data[3];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      data <= seed;
    else if (load)
      data <= ldata;
    else if (enable && !pause)
      data <= {data[6:0], feedback};
  end

endmodule

// ==== verilog/pattern_gen.sv ====
`timescale 1ns/1ps
`include "tg_params.svh"

module pattern_gen (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          step,
  input  logic          capture,
  input  logic          reload,
  output tg_pkg::data_t pattern
);
  import tg_pkg::*;

  data_t start_q;

  // first beat of the pass, replayed as the expected data of the reads
  always_ff @(posedge clk)
  begin
    if (capture)
      start_q <= pattern;
  end

  // ----------------------------------------
  // one LFSR per byte lane
  // ----------------------------------------
  for (genvar k = 0; k < `TG_LANES; k++)
  begin : g_lane
    lfsr8 #(
      .seed (lane_t'(`TG_SEED_BASE + k * `TG_SEED_STEP))
    ) u_lane (
      .clk     (clk),
      .reset_n (reset_n),
      .enable  (1'b1),
      .pause   (~step),
      .load    (reload),
      .ldata   (start_q[k]),
      .data    (pattern[k])
    );
  end

endmodule

// ==== verilog/read_checker.sv ====
`timescale 1ns/1ps

module read_checker (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               local_rdata_valid,
  input  tg_pkg::data_t      local_rdata,
  input  tg_pkg::data_t      expected,
  output tg_pkg::lane_mask_t pnf_per_byte,
  output logic               pnf_persist
);
  import tg_pkg::*;

  lane_mask_t lane_eq;
  lane_mask_t cmp_q;
  logic       vld_q;
  logic       res_q;
  logic       failed;

  always_comb
  begin
    for (int k = 0; k < $bits(lane_mask_t); k++)
      lane_eq[k] = (local_rdata[k] == expected[k]);
  end

  // raw compare, qualified one stage later
  always_ff @(posedge clk)
  begin
    cmp_q <= lane_eq;
  end

  // ----------------------------------------
  // result latch and sticky pass flag
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      vld_q        <= 1'b0;
      res_q        <= 1'b0;
      pnf_per_byte <= '1;
      failed       <= 1'b0;
      pnf_persist  <= 1'b0;
    end
    else
    begin
      vld_q <= local_rdata_valid;
      res_q <= vld_q;
      if (vld_q)
        pnf_per_byte <= cmp_q;
      if (res_q)
      begin
        // one bad lane holds the flag low until reset
        failed      <= failed || !(&pnf_per_byte);
        pnf_persist <= !failed && (&pnf_per_byte);
      end
    end
  end

endmodule

// ==== verilog/tg_addr_if.sv ====
`timescale 1ns/1ps

interface tg_addr_if;
  import tg_pkg::*;

  // current memory address
  cs_t   cs;
  bank_t bank;
  row_t  row;
  col_t  col;
  logic  last;

  // advance and restart requests
  logic  step;
  logic  clear;

  modport sweep (
    input  step,
    input  clear,
    output cs,
    output bank,
    output row,
    output col,
    output last
  );

  modport ctrl (
    input  last,
    output step,
    output clear
  );

endinterface

// ==== verilog/tg_params.svh ====
`ifndef TG_PARAMS_SVH
`define TG_PARAMS_SVH

// local port data path
`define TG_DATA_W     64
`define TG_LANES      (`TG_DATA_W / 8)

// address field widths
`define TG_CS_W       1
`define TG_BANK_W     3
`define TG_ROW_W      13
`define TG_COL_W      10

// beats per burst, also driven on local_size
`define TG_BURST_LEN  2
`define TG_COL_STEP   8

// last value of each field in the sweep
`define TG_MAX_COL    16
`define TG_MAX_ROW    3
`define TG_MAX_BANK   7
`define TG_MAX_CS     0

// lane k starts at base + k * step
`define TG_SEED_BASE  1
`define TG_SEED_STEP  10

`define TG_RD_CNT_W   8

`endif

// ==== verilog/tg_pkg.sv ====
`include "tg_params.svh"

package tg_pkg;

  // address fields of the local port
  typedef logic [`TG_CS_W-1:0]   cs_t;
  typedef logic [`TG_BANK_W-1:0] bank_t;
  typedef logic [`TG_ROW_W-1:0]  row_t;
  typedef logic [`TG_COL_W-1:0]  col_t;

  // data word as eight byte lanes, lane 0 in the low byte
  typedef logic [7:0]            lane_t;
  typedef lane_t [`TG_LANES-1:0] data_t;
  typedef logic [`TG_LANES-1:0]  lane_mask_t;

  // controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_FIRST,
    ST_WR_NEXT,
    ST_RD_ISSUE,
    ST_RD_DRAIN,
    ST_DONE
  } tg_state_e;

endpackage

// ==== verilog/traffic_ctrl.sv ====
`timescale 1ns/1ps
`include "tg_params.svh"

module traffic_ctrl (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    local_ready,
  input  logic    local_rdata_valid,
  tg_addr_if.ctrl addr,
  output logic    write_req,
  output logic    read_req,
  output logic    burst_begin,
  output logic    gen_step,
  output logic    gen_capture,
  output logic    gen_reload,
  output logic    test_complete
);
  import tg_pkg::*;

  typedef logic [`TG_RD_CNT_W-1:0] rd_cnt_t;

  localparam logic [3:0] LAST_BEAT = 4'(`TG_BURST_LEN - 1);
  localparam rd_cnt_t    RD_BURST  = rd_cnt_t'(`TG_BURST_LEN);

  tg_state_e  state;
  logic [3:0] beat_cnt;
  rd_cnt_t    rd_cnt;
  logic       first_burst;
  logic       wr_acc;
  logic       rd_acc;
  logic       wr_burst_end;
  logic       burst_end;

  // ----------------------------------------
  // request decode and handshake
  // ----------------------------------------
  assign write_req   = (state == ST_WR_FIRST) || (state == ST_WR_NEXT);
  assign read_req    = (state == ST_RD_ISSUE);
  assign burst_begin = (state == ST_WR_FIRST) || (state == ST_RD_ISSUE);

  assign wr_acc       = write_req && local_ready;
  assign rd_acc       = read_req && local_ready;
  assign wr_burst_end = wr_acc && (state == ST_WR_NEXT) && (beat_cnt == LAST_BEAT);
  assign burst_end    = wr_burst_end || rd_acc;

  // address moves once per burst, back to zero after the final one
  assign addr.step  = burst_end;
  assign addr.clear = burst_end && addr.last;

  // pattern advances per written beat and per returned beat
  assign gen_step    = wr_acc || local_rdata_valid;
  assign gen_capture = wr_acc && first_burst;
  assign gen_reload  = wr_burst_end && addr.last;

  // ----------------------------------------
  // phase FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= ST_IDLE;
      beat_cnt      <= '0;
      first_burst   <= 1'b0;
      test_complete <= 1'b0;
    end
    else
    begin
      test_complete <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          first_burst <= 1'b1;
          state       <= ST_WR_FIRST;
        end
        ST_WR_FIRST:
        begin
          if (wr_acc)
          begin
            first_burst <= 1'b0;
            beat_cnt    <= 4'd1;
            state       <= ST_WR_NEXT;
          end
        end
        ST_WR_NEXT:
        begin
          if (wr_burst_end)
          begin
            beat_cnt <= '0;
            state    <= addr.last ? ST_RD_ISSUE : ST_WR_FIRST;
          end
          else if (wr_acc)
            beat_cnt <= beat_cnt + 1'b1;
        end
        ST_RD_ISSUE:
        begin
          if (rd_acc && addr.last)
            state <= ST_RD_DRAIN;
        end
        ST_RD_DRAIN:
        begin
          if (rd_cnt == '0)
          begin
            test_complete <= 1'b1;
            state         <= ST_DONE;
          end
        end
        ST_DONE:
        begin
          // keeps test_complete up through the following idle cycle
          test_complete <= 1'b1;
          state         <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // read beats still owed by the controller
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      rd_cnt <= '0;
    else if (rd_acc && local_rdata_valid)
      rd_cnt <= rd_cnt + RD_BURST - 1'b1;
    else if (rd_acc)
      rd_cnt <= rd_cnt + RD_BURST;
    else if (local_rdata_valid && (rd_cnt != '0))
      rd_cnt <= rd_cnt - 1'b1;
  end

  no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!reset_n)
    !(write_req && read_req));

  // a stalled request keeps its burst marker until accepted
  wr_held: assert property (@(posedge clk) disable iff (!reset_n)
    (write_req && !local_ready) |=> (write_req && $stable(burst_begin)));

  rd_held: assert property (@(posedge clk) disable iff (!reset_n)
    (read_req && !local_ready) |=> (read_req && $stable(burst_begin)));

endmodule
